//--- scene_loader_params.svh
`ifndef SCENE_LOADER_PARAMS_SVH
`define SCENE_LOADER_PARAMS_SVH

// ##################################################
// UART timing
// ##################################################
`define CLKS_PER_BIT 16        // Oversampling clocks per serial bit

// ##################################################
// Scene store sizes and payload lengths
// ##################################################
`define NUM_OBJS     16        // Spheres in the object memory
`define OBJ_IDX_W    4         // Object index width
`define CAM_BYTES    9         // Bytes per camera vector payload
`define OBJ_BYTES    6         // Bytes per sphere payload

`endif

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

  typedef enum logic [1:0] {
    UART_IDLE,                 // Line high, waiting for start edge
    UART_START,                // Confirming start bit at half-bit
    UART_DATA,                 // Sampling eight data bits
    UART_STOP                  // Checking stop bit
  } uart_state_t;

  typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

//--- scene_pkg.sv
`default_nettype none

package scene_pkg;

  typedef enum logic [1:0] {
    CAM_ORIGIN,
    CAM_RIGHT,
    CAM_FORWARD,
    CAM_UP
  } cam_sel_t;

  // x sits in the low bits since payloads arrive LSB first
  typedef struct packed {
    logic [23:0] z;
    logic [23:0] y;
    logic [23:0] x;
  } cam_vec_t;

  typedef struct packed {
    logic [3:0]  material;
    logic [7:0]  radius;
    logic [11:0] center_z;
    logic [11:0] center_y;
    logic [11:0] center_x;       // First byte on the wire
  } scene_obj_t;

  typedef struct packed {
    logic       is_cam;          // Set for camera vector commands
    logic [6:0] index;           // cam_sel_t or object number
  } loader_cmd_t;

endpackage

`default_nettype wire

//--- scene_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

interface scene_wr_if import scene_pkg::*; ();

  logic                  cam_we;      // One-cycle camera write strobe
  cam_sel_t              cam_sel;
  cam_vec_t              cam_vec;

  logic                  obj_we;      // One-cycle object write strobe
  logic [`OBJ_IDX_W-1:0] obj_idx;
  scene_obj_t            obj;

  modport seq (
    output cam_we, cam_sel, cam_vec, obj_we, obj_idx, obj
  );

  modport store (
    input cam_we, cam_sel, cam_vec, obj_we, obj_idx, obj
  );

endinterface

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

module uart_rx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic       rx_valid,
  output uart_byte_t rx_byte
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

  logic             rxd_meta;
  logic             rxd_sync;
  uart_state_t      state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       shreg;

  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;             // Idle line level
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // ##################################################
  // Frame state machine
  // ##################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= UART_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_sync) state <= UART_START;
        end
        UART_START: begin
          if (clk_cnt == HALF_BIT) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? UART_IDLE : UART_DATA;   // Glitch returns to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            shreg   <= {rxd_sync, shreg[7:1]};              // LSB arrives first
            if (bit_idx == 3'd7) state <= UART_STOP;
            bit_idx <= bit_idx + 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            state   <= UART_IDLE;
            if (rxd_sync) begin
              rx_valid <= 1'b1;
              rx_byte  <= shreg;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- byte_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module byte_assembler import uart_pkg::*; #(
  parameter type payload_t = logic [7:0]
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,
  input  logic       shift_en,
  input  uart_byte_t rx_byte,
  output logic       full,
  output payload_t   payload
);

  localparam int PAY_W  = $bits(payload_t);
  localparam int NBYTES = PAY_W / 8;
  localparam int CNT_W  = $clog2(NBYTES + 1);

  logic [PAY_W-1:0] shreg;
  logic [CNT_W-1:0] byte_cnt;

  assign full    = (byte_cnt == CNT_W'(NBYTES));
  assign payload = payload_t'(shreg);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      byte_cnt <= '0;
    end else if (shift_en && !full) begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

  // New byte enters at the top so the first one ends at the bottom
  always_ff @(posedge clk) begin
    if (shift_en && !full && !clear) begin
      shreg <= {rx_byte, shreg[PAY_W-1:8]};
    end
  end

endmodule

`default_nettype wire

//--- scene_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

module scene_cmd_seq import uart_pkg::*, scene_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_valid,
  input  uart_byte_t rx_byte,
  input  logic       cam_full,
  input  logic       obj_full,
  input  cam_vec_t   cam_payload,
  input  scene_obj_t obj_payload,
  output logic       cam_clear,
  output logic       cam_shift,
  output logic       obj_clear,
  output logic       obj_shift,
  output logic       loader_busy,
  scene_wr_if.seq    wr
);

  localparam int DISC_W = $clog2(`OBJ_BYTES);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_CAM,
    SEQ_OBJ,
    SEQ_DISCARD
  } seq_state_t;

  seq_state_t        state;
  loader_cmd_t       cmd;
  logic              obj_ok;
  logic [DISC_W-1:0] disc_cnt;

  assign cmd    = loader_cmd_t'(rx_byte);
  assign obj_ok = (cmd.index < 7'(`NUM_OBJS));

  // ##################################################
  // Assembler steering
  // ##################################################
  assign cam_clear = (state == SEQ_IDLE) && rx_valid && cmd.is_cam;
  assign obj_clear = (state == SEQ_IDLE) && rx_valid && !cmd.is_cam && obj_ok;
  assign cam_shift = (state == SEQ_CAM) && rx_valid;
  assign obj_shift = (state == SEQ_OBJ) && rx_valid;

  assign wr.cam_vec = cam_payload;     // Held stable once the assembler is full
  assign wr.obj     = obj_payload;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= SEQ_IDLE;
      loader_busy <= 1'b0;
      disc_cnt    <= '0;
      wr.cam_we   <= 1'b0;
      wr.obj_we   <= 1'b0;
      wr.cam_sel  <= CAM_ORIGIN;
      wr.obj_idx  <= '0;
    end else begin
      wr.cam_we <= 1'b0;
      wr.obj_we <= 1'b0;
      case (state)
        SEQ_IDLE: if (rx_valid) begin
          loader_busy <= 1'b1;
          disc_cnt    <= '0;
          if (cmd.is_cam) begin
            wr.cam_sel <= cam_sel_t'(cmd.index[1:0]);
            state      <= SEQ_CAM;
          end else if (obj_ok) begin
            wr.obj_idx <= cmd.index[`OBJ_IDX_W-1:0];
            state      <= SEQ_OBJ;
          end else begin
            state <= SEQ_DISCARD;                          // Out-of-range object
          end
        end
        SEQ_CAM: if (cam_full) begin
          wr.cam_we   <= 1'b1;
          loader_busy <= 1'b0;
          state       <= SEQ_IDLE;
        end
        SEQ_OBJ: if (obj_full) begin
          wr.obj_we   <= 1'b1;
          loader_busy <= 1'b0;
          state       <= SEQ_IDLE;
        end
        SEQ_DISCARD: if (rx_valid) begin
          if (disc_cnt == DISC_W'(`OBJ_BYTES - 1)) begin
            loader_busy <= 1'b0;
            state       <= SEQ_IDLE;
          end
          disc_cnt <= disc_cnt + 1'b1;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cam_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cam_regs import scene_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  scene_wr_if.store wr,
  input  cam_sel_t rd_sel,
  output cam_vec_t rd_vec
);

  cam_vec_t vecs [4];       // Origin, right, forward, up

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        vecs[i] <= '0;
      end
    end else if (wr.cam_we) begin
      vecs[wr.cam_sel] <= wr.cam_vec;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    rd_vec <= vecs[rd_sel];
  end

endmodule

`default_nettype wire

//--- scene_obj_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

module scene_obj_mem import scene_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  scene_wr_if.store             wr,
  input  logic [`OBJ_IDX_W-1:0] rd_idx,
  output scene_obj_t            rd_obj
);

  scene_obj_t           mem [`NUM_OBJS];
  logic [`NUM_OBJS-1:0] valid;          // Entry written since reset

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wr.obj_we) begin
      valid[wr.obj_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.obj_we) mem[wr.obj_idx] <= wr.obj;
  end

  // Stale contents stay hidden until rewritten
  always_ff @(posedge clk) begin
    rd_obj <= valid[rd_idx] ? mem[rd_idx] : '0;
  end

endmodule

`default_nettype wire

//--- wb_scene_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

module wb_scene_port import scene_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [7:0]            wb_adr,
  output logic [31:0]           wb_dat_o,
  output logic                  wb_ack,
  output cam_sel_t              cam_sel,
  input  cam_vec_t              cam_vec,
  output logic [`OBJ_IDX_W-1:0] obj_idx,
  input  scene_obj_t            obj
);

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_CAM,
    REGION_OBJ
  } region_t;

  logic       start;
  logic       pending;
  logic [3:0] cam_word;
  region_t    region_d;
  region_t    region_q;
  logic [1:0] part_d;
  logic [1:0] part_q;

  // ##################################################
  // Address decode and store read address
  // ##################################################
  assign cam_word = wb_adr[3:0];
  assign cam_sel  = cam_sel_t'(2'(cam_word / 4'd3));
  assign obj_idx  = wb_adr[`OBJ_IDX_W:1];
  assign start    = wb_cyc && wb_stb && !pending && !wb_ack;

  always_comb begin
    region_d = REGION_NONE;
    part_d   = 2'd0;
    if (wb_we) begin
      region_d = REGION_NONE;                    // Writes read back zero
    end else if (wb_adr < 8'd12) begin
      region_d = REGION_CAM;
      part_d   = 2'(cam_word % 4'd3);            // x, y, z
    end else if (wb_adr[7:5] == 3'b001) begin
      region_d = REGION_OBJ;
      part_d   = {1'b0, wb_adr[0]};              // Low or high word
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      wb_ack  <= 1'b0;
    end else begin
      wb_ack  <= pending;
      pending <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      region_q <= region_d;
      part_q   <= part_d;
    end
  end

  // Pick and widen the word from the store read data
  always_ff @(posedge clk) begin
    if (pending) begin
      case (region_q)
        REGION_CAM: begin
          case (part_q)
            2'd0:    wb_dat_o <= {8'h00, cam_vec.x};
            2'd1:    wb_dat_o <= {8'h00, cam_vec.y};
            default: wb_dat_o <= {8'h00, cam_vec.z};
          endcase
        end
        REGION_OBJ: wb_dat_o <= part_q[0] ? {16'h0000, obj[47:32]} : obj[31:0];
        default:    wb_dat_o <= 32'h0000_0000;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- scene_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

module scene_loader_top import uart_pkg::*, scene_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        uart_rxd,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [7:0]  wb_adr,
  input  logic [31:0] wb_dat_i,       // Writes are acknowledged only
  output logic [31:0] wb_dat_o,
  output logic        wb_ack,
  output logic        loader_busy
);

  logic                  rx_valid;
  uart_byte_t            rx_byte;
  logic                  cam_clear;
  logic                  cam_shift;
  logic                  cam_full;
  cam_vec_t              cam_payload;
  logic                  obj_clear;
  logic                  obj_shift;
  logic                  obj_full;
  scene_obj_t            obj_payload;
  cam_sel_t              rd_cam_sel;
  cam_vec_t              rd_cam_vec;
  logic [`OBJ_IDX_W-1:0] rd_obj_idx;
  scene_obj_t            rd_obj;

  scene_wr_if wr_bus ();

  // ##################################################
  // Receive path
  // ##################################################
  uart_rx uart_rx_inst (
    .clk, .rst, .rxd(uart_rxd), .rx_valid, .rx_byte
  );

  byte_assembler #(.payload_t(cam_vec_t)) cam_asm_inst (
    .clk, .rst, .clear(cam_clear), .shift_en(cam_shift), .rx_byte,
    .full(cam_full), .payload(cam_payload)
  );

  byte_assembler #(.payload_t(scene_obj_t)) obj_asm_inst (
    .clk, .rst, .clear(obj_clear), .shift_en(obj_shift), .rx_byte,
    .full(obj_full), .payload(obj_payload)
  );

  scene_cmd_seq scene_cmd_seq_inst (
    .clk, .rst, .rx_valid, .rx_byte, .cam_full, .obj_full, .cam_payload, .obj_payload,
    .cam_clear, .cam_shift, .obj_clear, .obj_shift, .loader_busy, .wr(wr_bus.seq)
  );

  // ##################################################
  // Stores and bus port
  // ##################################################
  cam_regs cam_regs_inst (
    .clk, .rst, .wr(wr_bus.store), .rd_sel(rd_cam_sel), .rd_vec(rd_cam_vec)
  );

  scene_obj_mem scene_obj_mem_inst (
    .clk, .rst, .wr(wr_bus.store), .rd_idx(rd_obj_idx), .rd_obj
  );

  wb_scene_port wb_scene_port_inst (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_ack,
    .cam_sel(rd_cam_sel), .cam_vec(rd_cam_vec), .obj_idx(rd_obj_idx), .obj(rd_obj)
  );

endmodule

`default_nettype wire

//--- tb_scene_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "scene_loader_params.svh"

module tb_scene_loader;

  localparam int CLK_HALF   = 10;                       // 20 ns period
  localparam int DRIVE_DLY  = 1;                        // Inputs change just after the edge
  localparam int ACK_LIMIT  = 20;
  localparam int IDLE_LIMIT = 4 * 10 * `CLKS_PER_BIT;   // Several UART frames

  logic        clk;
  logic        rst;
  logic        uart_rxd;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack;
  logic        loader_busy;

  // Expected store contents packed LSB first as on the wire
  logic [71:0] cam_model [4];
  logic [47:0] obj_model [`NUM_OBJS];
  integer      seed;
  int          checks;
  int          errors;
  int          timeouts;

  scene_loader_top scene_loader_top_inst (
    .clk, .rst, .uart_rxd, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i,
    .wb_dat_o, .wb_ack, .loader_busy
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ##################################################
  // Helpers
  // ##################################################
  task automatic step_clk();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  // Camera words 0..11 and object words 32..63 map to the stores
  function automatic logic [31:0] expected_word(input logic [7:0] adr);
    logic [31:0] word;
    int          sel;
    int          idx;
    word = 32'h0000_0000;
    if (adr < 8'd12) begin
      sel  = adr / 3;
      word = {8'h00, cam_model[sel][(adr % 3) * 24 +: 24]};
    end else if (adr >= 8'd32 && adr <= 8'd63) begin
      idx  = (adr - 32) / 2;
      word = adr[0] ? {16'h0000, obj_model[idx][47:32]} : obj_model[idx][31:0];
    end
    return word;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ##################################################
  // UART driver and loader commands
  // ##################################################
  task automatic send_frame(input logic [7:0] data);
    uart_rxd = 1'b0;                                    // Start bit
    repeat (`CLKS_PER_BIT) step_clk();
    for (int i = 0; i < 8; i++) begin
      uart_rxd = data[i];
      repeat (`CLKS_PER_BIT) step_clk();
    end
    uart_rxd = 1'b1;                                    // Stop bit
    repeat (`CLKS_PER_BIT) step_clk();
  endtask

  task automatic send_command(input logic [7:0] cmd, input int nbytes,
                              output logic [71:0] payload);
    logic [7:0] b;
    payload = '0;
    send_frame(cmd);
    for (int i = 0; i < nbytes; i++) begin
      b = rand_byte();
      payload[i*8 +: 8] = b;
      send_frame(b);
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (loader_busy && waited < IDLE_LIMIT) begin
      step_clk();
      waited++;
    end
    if (loader_busy) begin
      timeouts++;
      $display("Timed out at %0t ns waiting for loader_busy to fall", $time);
    end
    repeat (2) step_clk();                              // Store write lands after busy falls
  endtask

  task automatic load_camera(input int sel);
    logic [71:0] p;
    send_command(8'h80 | 8'(sel), `CAM_BYTES, p);
    wait_idle();
    cam_model[sel] = p;
  endtask

  task automatic load_object(input int idx);
    logic [71:0] p;
    send_command({1'b0, 7'(idx)}, `OBJ_BYTES, p);
    wait_idle();
    obj_model[idx] = p[47:0];
  endtask

  // ##################################################
  // Wishbone master
  // ##################################################
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic acked);
    int waited;
    waited   = 0;
    rdata    = 'x;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    step_clk();
    while (!wb_ack && waited < ACK_LIMIT) begin
      step_clk();
      waited++;
    end
    acked = wb_ack;
    if (wb_ack) begin
      rdata = wb_dat_o;
    end else begin
      timeouts++;
      $display("Timed out at %0t ns waiting for Wishbone ack at address %h", $time, adr);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic check_word(input logic [7:0] adr);
    logic [31:0] got;
    logic        acked;
    bus_cycle(1'b0, adr, 32'h0, got, acked);
    check_value($sformatf("word %0d", adr), got, expected_word(adr));
  endtask

  task automatic check_all_words();
    for (int a = 0; a < 12; a++) check_word(8'(a));
    for (int a = 32; a < 64; a++) check_word(8'(a));
  endtask

  // ##################################################
  // Directed tests
  // ##################################################
  task automatic test_reset();
    check_value("loader_busy after reset", {31'b0, loader_busy}, 32'h0);
    check_all_words();
  endtask

  task automatic test_camera();
    for (int s = 0; s < 4; s++) load_camera(s);
    check_all_words();
  endtask

  task automatic test_objects();
    load_object(0);
    load_object(3);
    load_object(7);
    load_object(12);
    load_object(15);
    load_object(7);                                     // Overwrite
    check_all_words();
  endtask

  task automatic test_discard();
    send_frame(8'h14);                                  // Object 20 is out of range
    send_frame(8'h83);                                  // Looks like a command if not consumed
    repeat (5) send_frame(rand_byte());
    wait_idle();
    load_camera(2);
    check_all_words();
  endtask

  task automatic test_busy_and_bus();
    logic [71:0] p;
    logic [31:0] got;
    logic        acked;
    p = '0;
    send_frame(8'h81);
    check_value("loader_busy after command", {31'b0, loader_busy}, 32'h1);
    for (int i = 0; i < `CAM_BYTES; i++) begin
      p[i*8 +: 8] = rand_byte();
      send_frame(p[i*8 +: 8]);
      if (i == 3) check_value("loader_busy mid payload", {31'b0, loader_busy}, 32'h1);
    end
    wait_idle();
    check_value("loader_busy after payload", {31'b0, loader_busy}, 32'h0);
    cam_model[1] = p;

    bus_cycle(1'b1, 8'd0, 32'hffff_ffff, got, acked);
    check_value("write ack", {31'b0, acked}, 32'h1);
    check_value("write data", got, 32'h0);
    bus_cycle(1'b1, 8'd33, 32'h1234_5678, got, acked);
    check_value("write ack", {31'b0, acked}, 32'h1);
    check_value("write data", got, 32'h0);
    check_word(8'd12);                                  // Just past the camera words
    check_word(8'd20);
    check_word(8'h80);
    check_word(8'hff);
    check_all_words();
  endtask

  initial begin
    seed     = 32'h48e0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    rst      = 1'b1;
    uart_rxd = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 8'h00;
    wb_dat_i = 32'h0;
    for (int i = 0; i < 4; i++) cam_model[i] = '0;
    for (int i = 0; i < `NUM_OBJS; i++) obj_model[i] = '0;

    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    step_clk();

    test_reset();
    test_camera();
    test_objects();
    test_discard();
    test_busy_and_bus();

    $display("Checks: %0d  value errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- scene_loader_top.f
+incdir+.
uart_pkg.sv
scene_pkg.sv
scene_wr_if.sv
uart_rx.sv
byte_assembler.sv
scene_cmd_seq.sv
cam_regs.sv
scene_obj_mem.sv
wb_scene_port.sv
scene_loader_top.sv
tb_scene_loader.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scene_loader
FILELIST  ?= scene_loader_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
